/* src/conv_cfg_pkg.sv */
package conv_cfg_pkg;

  ////////////////////
  // element and word geometry

  // one argument element (bias, tail or rank)
  localparam int ELEM_W = 16;

  // elements packed in one buffer word, 32 x 16 = 512 bits
  localparam int WORD_ELEMS = 32;

  ////////////////////
  // register bank and addressing

  localparam int REG_DEPTH = 64; // channels per tile, one bank entry each
  localparam int SET_CH    = 4;  // channels handed to one systolic-array row

  // buffer word address, 512 words per buffer
  localparam int ADDR_W = 9;

  // output-channel count of a layer
  localparam int OC_W = 16;

endpackage

/* src/conv_arg_pkg.sv */
package conv_arg_pkg;

  ////////////////////
  // argument lanes

  localparam int N_LANES = 3;

  // lane index, also the host load_lane code
  localparam int LANE_BIAS = 0; // per-channel bias
  localparam int LANE_TAIL = 1; // e-scale tail
  localparam int LANE_RANK = 2; // e-scale rank

  ////////////////////
  // register start / size fields

  // start and size of one word write into a bank,
  // 7 bits so that a size of a full 64-entry bank still fits
  localparam int REG_IDX_W = 7;

endpackage

/* src/arg_buffer.sv */
module arg_buffer #(
  parameter int WORD_ELEMS = conv_cfg_pkg::WORD_ELEMS
)
(
  input  logic                                        clk,
  input  logic                                        en,
  input  logic                                        we,
  input  logic [conv_cfg_pkg::ADDR_W-1:0]             addr,
  input  logic [conv_cfg_pkg::ELEM_W*WORD_ELEMS-1:0]  din,
  output logic [conv_cfg_pkg::ELEM_W*WORD_ELEMS-1:0]  dout
);

  localparam int DEPTH  = 1 << conv_cfg_pkg::ADDR_W;
  localparam int WORD_W = conv_cfg_pkg::ELEM_W * WORD_ELEMS;

  logic [WORD_W-1:0] mem [DEPTH];

  // single port, write has priority over read on the same enable
  always_ff @(posedge clk)
  begin
    if (en)
    begin
      if (we)
        mem[addr] <= din;
      else
        dout <= mem[addr]; // one-cycle read latency
    end
  end

endmodule

/* src/args_sequencer.sv */
module args_sequencer #(
  parameter int REG_DEPTH  = conv_cfg_pkg::REG_DEPTH,
  parameter int WORD_ELEMS = conv_cfg_pkg::WORD_ELEMS
)
(
  input  logic                                                          clk,
  input  logic                                                          reset,
  input  logic                                                          layer_start,
  input  logic [conv_cfg_pkg::OC_W-1:0]                                 out_channels,
  input  logic [conv_cfg_pkg::ADDR_W-1:0]                               bias_base,
  input  logic [conv_cfg_pkg::ADDR_W-1:0]                               tail_base,
  input  logic [conv_cfg_pkg::ADDR_W-1:0]                               rank_base,
  input  logic                                                          refresh_req,
  output logic                                                          refresh_ack,
  output logic [conv_arg_pkg::N_LANES-1:0]                              rd_en,
  output logic [conv_arg_pkg::N_LANES-1:0][conv_cfg_pkg::ADDR_W-1:0]    rd_addr,
  output logic [conv_arg_pkg::REG_IDX_W-1:0]                            reg_start,
  output logic [conv_arg_pkg::REG_IDX_W-1:0]                            reg_size,
  output logic                                                          tile_clear
);

  localparam int WPT    = REG_DEPTH / WORD_ELEMS; // words per tile
  localparam int WIDX_W = $clog2(WPT + 1);
  localparam int CH_W   = conv_cfg_pkg::OC_W + 1; // room past the last channel

  // word0/word1 name the word now on the read port
  typedef enum logic [2:0] {
    S_IDLE, S_CLEAR, S_WORD0, S_WORD1, S_WAIT, S_ACK, S_RELEASE
  } state_t;

  state_t                                                        state;
  logic [conv_cfg_pkg::OC_W-1:0]                                 oc_q;
  logic [conv_arg_pkg::N_LANES-1:0][conv_cfg_pkg::ADDR_W-1:0]    base_q;
  logic [conv_cfg_pkg::OC_W-1:0]                                 tile;
  logic [WIDX_W-1:0]                                             word_idx;
  logic [WIDX_W-1:0]                                             cur_word;
  logic [CH_W-1:0]                                               word_ch;
  logic [CH_W-1:0]                                               left;
  logic [conv_arg_pkg::REG_IDX_W-1:0]                            word_size;
  logic [conv_cfg_pkg::ADDR_W-1:0]                               word_off;
  logic                                                          last_tile;
  logic                                                          issue;

  ////////////////////
  // word sizing and addressing

  assign cur_word  = (state == S_CLEAR) ? '0 : word_idx;
  assign word_ch   = CH_W'(tile * REG_DEPTH) + CH_W'(cur_word * WORD_ELEMS);
  assign left      = (CH_W'(oc_q) > word_ch) ? CH_W'(oc_q) - word_ch : '0;
  assign word_size = (left >= CH_W'(WORD_ELEMS)) ? conv_arg_pkg::REG_IDX_W'(WORD_ELEMS)
                                                 : conv_arg_pkg::REG_IDX_W'(left);
  assign word_off  = conv_cfg_pkg::ADDR_W'(tile * WPT) + conv_cfg_pkg::ADDR_W'(cur_word);
  assign last_tile = ((tile + 1) * REG_DEPTH) >= oc_q; // tile holding channel oc-1

  // a word goes out in clear and in each word state until all WPT are sent
  assign issue = (state == S_CLEAR) ||
                 (((state == S_WORD0) || (state == S_WORD1)) && (word_idx < WPT));

  ////////////////////
  // tile FSM and handshake

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= S_IDLE;
      oc_q        <= '0;
      base_q      <= '0;
      tile        <= '0;
      word_idx    <= '0;
      refresh_ack <= 1'b0;
      rd_en       <= '0;
      tile_clear  <= 1'b0;
      reg_start   <= '0;
      reg_size    <= '0;
    end
    else
    begin
      tile_clear <= (state == S_CLEAR);
      rd_en      <= {conv_arg_pkg::N_LANES{issue && (word_size != '0)}}; // empty words skipped
      if (issue)
      begin
        reg_start <= conv_arg_pkg::REG_IDX_W'(cur_word * WORD_ELEMS);
        reg_size  <= word_size;
      end

      case (state)
        S_IDLE:
          if (refresh_req)
            state <= S_CLEAR;
        S_CLEAR:
        begin
          word_idx <= WIDX_W'(1);
          state    <= S_WORD0;
        end
        S_WORD0, S_WORD1:
        begin
          if (word_idx < WPT)
          begin
            word_idx <= word_idx + 1'b1;
            state    <= S_WORD1;
          end
          else
            state <= S_WAIT;
        end
        S_WAIT:
          state <= S_ACK; // last word still in the lane pipeline
        S_ACK:
        begin
          refresh_ack <= 1'b1;
          state       <= S_RELEASE;
        end
        S_RELEASE:
          if (!refresh_req)
          begin
            refresh_ack <= 1'b0;
            tile        <= last_tile ? '0 : tile + 1'b1; // wrap after the last tile
            state       <= S_IDLE;
          end
        default:
          state <= S_IDLE;
      endcase

      if (layer_start)
      begin
        oc_q                            <= out_channels;
        base_q[conv_arg_pkg::LANE_BIAS] <= bias_base;
        base_q[conv_arg_pkg::LANE_TAIL] <= tail_base;
        base_q[conv_arg_pkg::LANE_RANK] <= rank_base;
        tile                            <= '0;
      end
    end
  end

  // each lane reads at its own base, same offset
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      for (int l = 0; l < conv_arg_pkg::N_LANES; l++)
        rd_addr[l] <= base_q[l] + word_off;
    end
  end

  ack_after_req: assert property (@(posedge clk) disable iff (reset)
    $rose(refresh_ack) |-> $past(refresh_req));

  write_in_bank: assert property (@(posedge clk) disable iff (reset)
    (reg_start + reg_size) <= REG_DEPTH);

endmodule

/* src/arg_lane.sv */
module arg_lane #(
  parameter int REG_DEPTH  = conv_cfg_pkg::REG_DEPTH,
  parameter int WORD_ELEMS = conv_cfg_pkg::WORD_ELEMS
)
(
  input  logic                                              clk,
  input  logic                                              reset,
  input  logic                                              load_en,
  input  logic [conv_cfg_pkg::ADDR_W-1:0]                   load_addr,
  input  logic [conv_cfg_pkg::ELEM_W*WORD_ELEMS-1:0]        load_data,
  input  logic                                              rd_en,
  input  logic [conv_cfg_pkg::ADDR_W-1:0]                   rd_addr,
  input  logic [conv_arg_pkg::REG_IDX_W-1:0]                reg_start,
  input  logic [conv_arg_pkg::REG_IDX_W-1:0]                reg_size,
  input  logic                                              tile_clear,
  output logic [REG_DEPTH-1:0][conv_cfg_pkg::ELEM_W-1:0]    bank
);

  logic                                              buf_en;
  logic [conv_cfg_pkg::ADDR_W-1:0]                   buf_addr;
  logic [WORD_ELEMS-1:0][conv_cfg_pkg::ELEM_W-1:0]   buf_dout;
  logic                                              last_valid;
  logic [conv_arg_pkg::REG_IDX_W-1:0]                last_start;
  logic [conv_arg_pkg::REG_IDX_W-1:0]                last_size;

  ////////////////////
  // buffer port

  assign buf_en   = load_en | rd_en;
  assign buf_addr = load_en ? load_addr : rd_addr; // host owns the port while loading

  arg_buffer #(
    .WORD_ELEMS (WORD_ELEMS)
  ) u_buf (
    .clk  (clk),
    .en   (buf_en),
    .we   (load_en),
    .addr (buf_addr),
    .din  (load_data),
    .dout (buf_dout)
  );

  ////////////////////
  // last regs, line up with read data

  always_ff @(posedge clk)
  begin
    if (reset)
      last_valid <= 1'b0;
    else
      last_valid <= rd_en;
  end

  always_ff @(posedge clk)
  begin
    last_start <= reg_start;
    last_size  <= reg_size;
  end

  // bank write, entries outside [start, start+size) keep their value
  always_ff @(posedge clk)
  begin
    if (reset || tile_clear)
      bank <= '0;
    else if (last_valid)
    begin
      for (int j = 0; j < REG_DEPTH; j++)
      begin
        if ((j >= last_start) && (j < last_start + last_size))
          bank[j] <= buf_dout[j - last_start];
      end
    end
  end

  // host must stay off the buffer during a refresh
  no_load_on_read: assert property (@(posedge clk) disable iff (reset)
    !(load_en && rd_en));

endmodule

/* src/channel_set_selector.sv */
module channel_set_selector #(
  parameter int REG_DEPTH = conv_cfg_pkg::REG_DEPTH
)
(
  input  logic                                                                     clk,
  input  logic                                                                     reset,
  input  logic [3:0]                                                               out_row_idx,
  input  logic [conv_arg_pkg::N_LANES-1:0][REG_DEPTH-1:0][conv_cfg_pkg::ELEM_W-1:0] banks,
  output logic [conv_cfg_pkg::SET_CH*conv_cfg_pkg::ELEM_W-1:0]                      bias_sets,
  output logic [conv_cfg_pkg::SET_CH*conv_cfg_pkg::ELEM_W-1:0]                      tail_sets,
  output logic [conv_cfg_pkg::SET_CH*conv_cfg_pkg::ELEM_W-1:0]                      rank_sets
);

  localparam int BASE_W = 4 + $clog2(conv_cfg_pkg::SET_CH);

  logic [BASE_W-1:0] row_base;
  logic [conv_arg_pkg::N_LANES-1:0][conv_cfg_pkg::SET_CH-1:0][conv_cfg_pkg::ELEM_W-1:0] sets_q;

  assign row_base = BASE_W'(out_row_idx * conv_cfg_pkg::SET_CH); // first channel of the row

  // drain, four channels of every lane per row
  always_ff @(posedge clk)
  begin
    if (reset)
      sets_q <= '0;
    else
    begin
      for (int l = 0; l < conv_arg_pkg::N_LANES; l++)
      begin
        for (int k = 0; k < conv_cfg_pkg::SET_CH; k++)
        begin
          if (row_base + k < REG_DEPTH)
            sets_q[l][k] <= banks[l][row_base + k];
          else
            sets_q[l][k] <= '0; // row past a short bank
        end
      end
    end
  end

  assign bias_sets = sets_q[conv_arg_pkg::LANE_BIAS];
  assign tail_sets = sets_q[conv_arg_pkg::LANE_TAIL];
  assign rank_sets = sets_q[conv_arg_pkg::LANE_RANK];

endmodule

/* src/conv_args_top.sv */
module conv_args_top #(
  parameter int REG_DEPTH  = conv_cfg_pkg::REG_DEPTH,
  parameter int WORD_ELEMS = conv_cfg_pkg::WORD_ELEMS
)
(
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  logic                                                  load_en,
  input  logic [$clog2(conv_arg_pkg::N_LANES)-1:0]              load_lane,
  input  logic [conv_cfg_pkg::ADDR_W-1:0]                       load_addr,
  input  logic [conv_cfg_pkg::ELEM_W*WORD_ELEMS-1:0]            load_data,
  input  logic                                                  layer_start,
  input  logic [conv_cfg_pkg::OC_W-1:0]                         out_channels,
  input  logic [conv_cfg_pkg::ADDR_W-1:0]                       bias_base,
  input  logic [conv_cfg_pkg::ADDR_W-1:0]                       tail_base,
  input  logic [conv_cfg_pkg::ADDR_W-1:0]                       rank_base,
  input  logic                                                  refresh_req,
  output logic                                                  refresh_ack,
  input  logic [3:0]                                            out_row_idx,
  output logic [conv_cfg_pkg::SET_CH*conv_cfg_pkg::ELEM_W-1:0]  bias_sets,
  output logic [conv_cfg_pkg::SET_CH*conv_cfg_pkg::ELEM_W-1:0]  tail_sets,
  output logic [conv_cfg_pkg::SET_CH*conv_cfg_pkg::ELEM_W-1:0]  rank_sets
);

  localparam int LANE_SEL_W = $clog2(conv_arg_pkg::N_LANES);

  logic [conv_arg_pkg::N_LANES-1:0]                                                 rd_en;
  logic [conv_arg_pkg::N_LANES-1:0][conv_cfg_pkg::ADDR_W-1:0]                       rd_addr;
  logic [conv_arg_pkg::REG_IDX_W-1:0]                                               reg_start;
  logic [conv_arg_pkg::REG_IDX_W-1:0]                                               reg_size;
  logic                                                                             tile_clear;
  logic [conv_arg_pkg::N_LANES-1:0]                                                 lane_load_en;
  logic [conv_arg_pkg::N_LANES-1:0][REG_DEPTH-1:0][conv_cfg_pkg::ELEM_W-1:0]        banks;

  args_sequencer #(
    .REG_DEPTH  (REG_DEPTH),
    .WORD_ELEMS (WORD_ELEMS)
  ) u_seq (
    .clk          (clk),
    .reset        (reset),
    .layer_start  (layer_start),
    .out_channels (out_channels),
    .bias_base    (bias_base),
    .tail_base    (tail_base),
    .rank_base    (rank_base),
    .refresh_req  (refresh_req),
    .refresh_ack  (refresh_ack),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .reg_start    (reg_start),
    .reg_size     (reg_size),
    .tile_clear   (tile_clear)
  );

  ////////////////////
  // argument lanes

  for (genvar l = 0; l < conv_arg_pkg::N_LANES; l++)
  begin : g_lane
    localparam logic [LANE_SEL_W-1:0] LANE_ID = LANE_SEL_W'(l);

    assign lane_load_en[l] = load_en && (load_lane == LANE_ID); // host lane decode

    arg_lane #(
      .REG_DEPTH  (REG_DEPTH),
      .WORD_ELEMS (WORD_ELEMS)
    ) u_lane (
      .clk        (clk),
      .reset      (reset),
      .load_en    (lane_load_en[l]),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .rd_en      (rd_en[l]),
      .rd_addr    (rd_addr[l]),
      .reg_start  (reg_start),
      .reg_size   (reg_size),
      .tile_clear (tile_clear),
      .bank       (banks[l])
    );
  end

  channel_set_selector #(
    .REG_DEPTH (REG_DEPTH)
  ) u_sel (
    .clk         (clk),
    .reset       (reset),
    .out_row_idx (out_row_idx),
    .banks       (banks),
    .bias_sets   (bias_sets),
    .tail_sets   (tail_sets),
    .rank_sets   (rank_sets)
  );

endmodule

/* dv/conv_args_tb.sv */
module conv_args_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_LAYERS    = 3;
  localparam int MAX_TILES   = 4;          // 200 channels at most
  localparam int TILE_CYCLES = 40;
  localparam int LOAD_CYCLES = 3 * 7 + 4;  // three lanes, 7 words each
  localparam int WATCHDOG_CYCLES =
    N_LAYERS * ((MAX_TILES + 1) * TILE_CYCLES + LOAD_CYCLES) + 20;

  logic         clk;
  logic         reset;
  logic         load_en;
  logic [1:0]   load_lane;
  logic [8:0]   load_addr;
  logic [511:0] load_data;
  logic         layer_start;
  logic [15:0]  out_channels;
  logic [8:0]   bias_base;
  logic [8:0]   tail_base;
  logic [8:0]   rank_base;
  logic         refresh_req;
  logic         refresh_ack;
  logic [3:0]   out_row_idx;
  logic [63:0]  bias_sets;
  logic [63:0]  tail_sets;
  logic [63:0]  rank_sets;

  // reference state of the layer in flight
  logic [15:0]  lfsr;
  int           exp_oc;
  int           exp_tile;
  int           exp_base [3];

  conv_args_top uut (
    .clk          (clk),
    .reset        (reset),
    .load_en      (load_en),
    .load_lane    (load_lane),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .layer_start  (layer_start),
    .out_channels (out_channels),
    .bias_base    (bias_base),
    .tail_base    (tail_base),
    .rank_base    (rank_base),
    .refresh_req  (refresh_req),
    .refresh_ack  (refresh_ack),
    .out_row_idx  (out_row_idx),
    .bias_sets    (bias_sets),
    .tail_sets    (tail_sets),
    .rank_sets    (rank_sets)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // helpers

  function automatic logic [15:0] galois_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic int take_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = galois_step(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // stored value of element e at word address addr of a lane
  function automatic logic [15:0] word_elem(int lane, int addr, int e);
    return 16'(lane * 4096 + 32 * addr + e);
  endfunction

  function automatic logic [63:0] expected_set(int lane, logic [3:0] row, int tile,
                                               int oc, int base);
    logic [63:0] v;
    int          ch;
    v = '0;
    for (int k = 0; k < 4; k++)
    begin
      ch = 64 * tile + 4 * int'(row) + k;
      if (ch < oc)
        v[16*k +: 16] = word_elem(lane, base + ch / 32, ch % 32); // else stays zero
    end
    return v;
  endfunction

  task automatic report_error(string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic wait_ack(logic level);
    while (refresh_ack !== level)
      next_cycle();
  endtask

  task automatic load_words(int lane, int base, int n_words);
    for (int w = 0; w < n_words; w++)
    begin
      load_en   = 1'b1;
      load_lane = 2'(lane);
      load_addr = 9'(base + w);
      for (int e = 0; e < 32; e++)
        load_data[16*e +: 16] = word_elem(lane, base + w, e);
      next_cycle();
    end
    load_en = 1'b0;
  endtask

  // one tile: request, sweep the rows, hold, release
  task automatic refresh_tile(int n_tiles);
    refresh_req = 1'b1;
    wait_ack(1'b1);
    for (int r = 0; r < 16; r++)
    begin
      out_row_idx = 4'(r);
      next_cycle();
    end
    repeat (4)
    begin
      out_row_idx = 4'(take_bits(4));
      next_cycle();
    end
    repeat (3 + take_bits(2)) next_cycle(); // back-pressure
    refresh_req = 1'b0;
    wait_ack(1'b0);
    exp_tile = (exp_tile + 1 == n_tiles) ? 0 : exp_tile + 1;
  endtask

  task automatic run_layer(int layer);
    int oc;
    int n_tiles;
    if (layer == 0)
      oc = 65 + take_bits(6) % 63; // full tile, then a partial one
    else
      oc = 1 + take_bits(8) % 200;
    n_tiles = (oc + 63) / 64;
    for (int l = 0; l < 3; l++)
    begin
      exp_base[l] = take_bits(8);
      load_words(l, exp_base[l], (oc + 31) / 32);
    end
    layer_start  = 1'b1;
    out_channels = 16'(oc);
    bias_base    = 9'(exp_base[0]);
    tail_base    = 9'(exp_base[1]);
    rank_base    = 9'(exp_base[2]);
    exp_oc       = oc;
    exp_tile     = 0;
    next_cycle();
    layer_start = 1'b0;
    // one extra refresh to see the wrap back to tile 0
    for (int t = 0; t <= n_tiles; t++)
      refresh_tile(n_tiles);
  endtask

  ////////////////////
  // checks

  reset_zero: assert property (@(posedge clk) $fell(reset) |->
    (!refresh_ack && bias_sets == '0 && tail_sets == '0 && rank_sets == '0))
    else report_error("outputs not zero after reset");

  // ack edge lands 5 edges after req is first seen
  ack_in_time: assert property (@(posedge clk) disable iff (reset)
    $rose(refresh_req) |-> ##6 refresh_ack)
    else report_error("refresh_ack did not rise in time after refresh_req");

  ack_holds: assert property (@(posedge clk) disable iff (reset)
    (refresh_ack && refresh_req) |=> refresh_ack)
    else report_error("refresh_ack dropped while refresh_req was still high");

  ack_release: assert property (@(posedge clk) disable iff (reset)
    (refresh_ack && !refresh_req) |=> !refresh_ack)
    else report_error("refresh_ack stayed high after refresh_req fell");

  bias_data: assert property (@(posedge clk) disable iff (reset)
    (refresh_ack && $past(refresh_ack)) |->
      bias_sets == expected_set(0, $past(out_row_idx), exp_tile, exp_oc, exp_base[0]))
    else report_error($sformatf("bias_sets is %h in tile %0d", bias_sets, exp_tile));

  tail_data: assert property (@(posedge clk) disable iff (reset)
    (refresh_ack && $past(refresh_ack)) |->
      tail_sets == expected_set(1, $past(out_row_idx), exp_tile, exp_oc, exp_base[1]))
    else report_error($sformatf("tail_sets is %h in tile %0d", tail_sets, exp_tile));

  rank_data: assert property (@(posedge clk) disable iff (reset)
    (refresh_ack && $past(refresh_ack)) |->
      rank_sets == expected_set(2, $past(out_row_idx), exp_tile, exp_oc, exp_base[2]))
    else report_error($sformatf("rank_sets is %h in tile %0d", rank_sets, exp_tile));

  ////////////////////
  // stimulus and watchdog

  initial
  begin
    reset        = 1'b1;
    load_en      = 1'b0;
    load_lane    = '0;
    load_addr    = '0;
    load_data    = '0;
    layer_start  = 1'b0;
    out_channels = '0;
    bias_base    = '0;
    tail_base    = '0;
    rank_base    = '0;
    refresh_req  = 1'b0;
    out_row_idx  = '0;
    exp_oc       = 0;
    exp_tile     = 0;
    exp_base     = '{0, 0, 0};
    lfsr         = 16'd54255;
    repeat (3) @(posedge clk);
    #5;
    reset = 1'b0;
    repeat (2) next_cycle();
    for (int layer = 0; layer < N_LAYERS; layer++)
      run_layer(layer);
    repeat (2) next_cycle();
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* project.f */
src/conv_cfg_pkg.sv
src/conv_arg_pkg.sv
src/arg_buffer.sv
src/args_sequencer.sv
src/arg_lane.sv
src/channel_set_selector.sv
src/conv_args_top.sv
dv/conv_args_tb.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then judge the result from sim.log
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal --top-module conv_args_tb \
    -f project.f -o conv_args_sim &&
  ./obj_dir/conv_args_sim; } > sim.log 2>&1
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"
